// ==== design/icache_cfg.svh ====
// icache configuration: address split, word and line geometry, refill beat count
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// --------------------------------------------------
// address geometry
// --------------------------------------------------

`define ICACHE_ADDR_W    32   // physical address
`define ICACHE_OFFSET_W  5    // byte offset in a 32-byte line
`define ICACHE_INDEX_W   6    // set index
`define ICACHE_TAG_W     21   // addr - index - offset

// --------------------------------------------------
// storage geometry
// --------------------------------------------------

`define ICACHE_WORD_W    64   // cpu and bus word
`define ICACHE_LINE_W    256  // one line, four words
`define ICACHE_SETS      64   // sets per way

// 4 KB total over two ways of 64 sets

// --------------------------------------------------
// refill
// --------------------------------------------------

`define ICACHE_BEATS     4    // return beats per line
`define ICACHE_BEAT_W    2    // beat counter, also word select

// word select sits at offset[4:3]; offset[2:0] is the byte
// within a word and is ignored by the cache

`endif

// ==== design/icache_pkg.sv ====
// icache types: controller state, address split, bus request and return beat
`include "icache_cfg.svh"

package icache_pkg;

  // --------------------------------------------------
  // controller states
  // --------------------------------------------------

  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // waiting for a request
    LOOKUP = 2'd1,  // tag compare on the buffered request
    MISS   = 2'd2,  // line read posted to the bus
    REFILL = 2'd3   // taking return beats
  } icache_state_e;

  // --------------------------------------------------
  // data types
  // --------------------------------------------------

  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  typedef logic [`ICACHE_LINE_W-1:0] line_t;

  // cpu address, split as the array sees it
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } cache_addr_t;

  // line read request to the bus
  typedef struct packed {
    logic                      req;   // held until rd_rdy
    logic [`ICACHE_ADDR_W-1:0] addr;  // line aligned
  } bus_rd_t;

  // one return beat from the bus
  typedef struct packed {
    logic  valid;
    logic  last;  // fourth beat of the line
    word_t data;
  } ret_beat_t;

endpackage

// ==== design/icache_ctrl.sv ====
// icache controller: request FSM, request buffer and the CPU and bus control outputs
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,         // cpu request strobe
  input  cache_addr_t                i_addr,
  input  logic                       i_hit,           // from tag array
  input  logic                       i_critical,      // requested word on the bus
  input  ret_beat_t                  i_ret,
  input  logic                       i_rd_rdy,
  output logic                       o_addr_ok,
  output logic                       o_data_ok,
  output icache_state_e              o_state,
  output cache_addr_t                o_req,
  output logic [`ICACHE_INDEX_W-1:0] o_lookup_index,
  output bus_rd_t                    o_rd
);

  icache_state_e state_q;
  icache_state_e state_d;
  cache_addr_t   req_q;
  logic          lookup_hit;
  logic          accept;

  assign lookup_hit = (state_q == LOOKUP) && i_hit;
  assign o_addr_ok  = (state_q == IDLE) || lookup_hit;
  assign accept     = i_valid && o_addr_ok;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!i_hit) begin
          state_d = MISS;
        end else if (!i_valid) begin
          state_d = IDLE;  // hit with nothing queued behind it
        end
      end
      MISS: begin
        if (i_rd_rdy) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (i_ret.valid && i_ret.last) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // request buffer
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_q <= i_addr;  // also taken on a hit in LOOKUP
    end
  end

  // the data array must see the new index in the accept cycle so that
  // the word is ready in LOOKUP one cycle later
  assign o_lookup_index = accept ? i_addr.index : req_q.index;

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  assign o_data_ok = lookup_hit || i_critical;
  assign o_state   = state_q;
  assign o_req     = req_q;

  assign o_rd.req  = (state_q == MISS);  // drops in the rd_rdy cycle
  assign o_rd.addr = {req_q.tag, req_q.index, {`ICACHE_OFFSET_W{1'b0}}};

endmodule

// ==== design/icache_tag_array.sv ====
// icache tag array: per-way tag and valid storage, hit compare and tag fill after refill
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_tag_array import icache_pkg::*; (
  input  logic          i_clk,
  input  logic          i_rst,
  input  icache_state_e i_state,
  input  cache_addr_t   i_req,     // buffered request
  input  logic          i_victim,  // way being refilled
  input  ret_beat_t     i_ret,
  output logic          o_hit,
  output logic          o_hit_way
);

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  logic [`ICACHE_TAG_W-1:0] tag_mem [2][`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]  valid_q [2];

  logic       fill_en;
  logic [1:0] way_hit;

  // tag and valid go in together with the last data word
  assign fill_en = (i_state == REFILL) && i_ret.valid && i_ret.last;

  always_ff @(posedge i_clk) begin
    if (fill_en) begin
      tag_mem[i_victim][i_req.index] <= i_req.tag;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end else if (fill_en) begin
      valid_q[i_victim][i_req.index] <= 1'b1;
    end
  end

  // --------------------------------------------------
  // hit compare
  // --------------------------------------------------

  // compare both ways against the stored request, no register
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w][i_req.index] &&
                   (tag_mem[w][i_req.index] == i_req.tag);
    end
  end

  assign o_hit     = |way_hit;
  assign o_hit_way = way_hit[1];  // one-hot by construction

  // a line is only ever filled into one way, since a refill follows
  // a miss in both ways of the same set

endmodule

// ==== design/icache_data_array.sv ====
// icache data array: two ways of line storage, synchronous read, word select, refill writes
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_data_array import icache_pkg::*; (
  input  logic                       i_clk,
  input  icache_state_e              i_state,
  input  logic [`ICACHE_INDEX_W-1:0] i_lookup_index,
  input  cache_addr_t                i_req,
  input  logic                       i_hit_way,
  input  logic                       i_victim,
  input  logic [`ICACHE_BEAT_W-1:0]  i_beat,
  input  ret_beat_t                  i_ret,
  output word_t                      o_rdata
);

  logic                       refill_we;
  logic [`ICACHE_BEATS-1:0]   word_we;  // one-hot from beat count
  logic [`ICACHE_BEAT_W-1:0]  word_sel;
  line_t                      rd_line_q [2];
  line_t                      hit_line;
  word_t                      hit_word;

  assign refill_we = (i_state == REFILL) && i_ret.valid;

  always_comb begin
    for (int b = 0; b < `ICACHE_BEATS; b++) begin
      word_we[b] = (i_beat == b[`ICACHE_BEAT_W-1:0]);
    end
  end

  // --------------------------------------------------
  // way storage
  // --------------------------------------------------

  for (genvar w = 0; w < 2; w++) begin : g_way
    line_t mem [`ICACHE_SETS];
    logic  way_we;

    assign way_we = refill_we && (i_victim == w[0]);

    always_ff @(posedge i_clk) begin
      for (int b = 0; b < `ICACHE_BEATS; b++) begin
        if (way_we && word_we[b]) begin
          mem[i_req.index][b*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= i_ret.data;
        end
      end
    end

    // read every cycle, old data on a same-cycle write
    always_ff @(posedge i_clk) begin
      rd_line_q[w] <= mem[i_lookup_index];
    end
  end

  // --------------------------------------------------
  // word select
  // --------------------------------------------------

  assign word_sel = i_req.offset[`ICACHE_OFFSET_W-1 -: `ICACHE_BEAT_W];  // offset[4:3]
  assign hit_line = rd_line_q[i_hit_way];
  assign hit_word = hit_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

  // on a miss the critical word comes straight from the bus
  assign o_rdata = (i_state == LOOKUP) ? hit_word : i_ret.data;

endmodule

// ==== design/icache_miss_buffer.sv ====
// icache miss buffer: round-robin victim choice, return beat counter and critical word detect
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_miss_buffer import icache_pkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  icache_state_e             i_state,
  input  cache_addr_t               i_req,
  input  ret_beat_t                 i_ret,
  output logic                      o_victim,
  output logic [`ICACHE_BEAT_W-1:0] o_beat,
  output logic                      o_critical
);

  logic                      rr_q;      // next way to replace
  logic                      victim_q;
  logic [`ICACHE_BEAT_W-1:0] beat_q;
  logic                      beat_en;

  assign beat_en = (i_state == REFILL) && i_ret.valid;

  // --------------------------------------------------
  // victim choice
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_q     <= 1'b0;  // first refill goes to way 0
      victim_q <= 1'b0;
    end else begin
      if (i_state == MISS) begin
        victim_q <= rr_q;
      end
      if (beat_en && i_ret.last) begin
        rr_q <= ~rr_q;  // flip once per completed line
      end
    end
  end

  // --------------------------------------------------
  // beat counter
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst || (i_state == MISS)) begin
      beat_q <= '0;
    end else if (beat_en) begin
      beat_q <= beat_q + 1'b1;  // wraps after the fourth beat
    end
  end

  assign o_victim   = victim_q;
  assign o_beat     = beat_q;
  assign o_critical = beat_en && (beat_q == i_req.offset[`ICACHE_OFFSET_W-1 -: `ICACHE_BEAT_W]);

endmodule

// ==== design/icache_top.sv ====
// icache top: two-way read-only instruction cache with line refill over a simple bus
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_top import icache_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst,
  // cpu side
  input  logic        i_valid,
  input  cache_addr_t i_addr,
  output logic        o_addr_ok,
  output logic        o_data_ok,
  output word_t       o_rdata,
  // bus side
  output bus_rd_t     o_rd,
  input  logic        i_rd_rdy,
  input  ret_beat_t   i_ret
);

  // --------------------------------------------------
  // internal wires
  // --------------------------------------------------

  icache_state_e              state;
  cache_addr_t                req;
  logic [`ICACHE_INDEX_W-1:0] lookup_index;
  logic                       hit;
  logic                       hit_way;
  logic                       victim;
  logic [`ICACHE_BEAT_W-1:0]  beat;
  logic                       critical;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  icache_ctrl icache_ctrl_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_addr         (i_addr),
    .i_hit          (hit),
    .i_critical     (critical),
    .i_ret          (i_ret),
    .i_rd_rdy       (i_rd_rdy),
    .o_addr_ok      (o_addr_ok),
    .o_data_ok      (o_data_ok),
    .o_state        (state),
    .o_req          (req),
    .o_lookup_index (lookup_index),
    .o_rd           (o_rd)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  icache_tag_array icache_tag_array_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_state   (state),
    .i_req     (req),
    .i_victim  (victim),
    .i_ret     (i_ret),
    .o_hit     (hit),
    .o_hit_way (hit_way)
  );

  icache_data_array icache_data_array_i (
    .i_clk          (i_clk),
    .i_state        (state),
    .i_lookup_index (lookup_index),
    .i_req          (req),
    .i_hit_way      (hit_way),
    .i_victim       (victim),
    .i_beat         (beat),
    .i_ret          (i_ret),
    .o_rdata        (o_rdata)
  );

  icache_miss_buffer icache_miss_buffer_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_state    (state),
    .i_req      (req),
    .i_ret      (i_ret),
    .o_victim   (victim),
    .o_beat     (beat),
    .o_critical (critical)
  );

endmodule

// ==== dv/icache_tb.sv ====
// icache testbench with a bus memory model, reference data and in-order read checks
`timescale 1ns/100ps
`include "icache_cfg.svh"

module icache_tb import icache_pkg::*; ();

  // a miss takes at most about 14 cycles so 230 reads with idle gaps stay near 3400
  localparam int MAX_CYCLES = 4000;
  localparam int RAND_READS = 200;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  cache_addr_t i_addr;
  logic        o_addr_ok;
  logic        o_data_ok;
  word_t       o_rdata;
  bus_rd_t     o_rd;
  logic        i_rd_rdy;
  ret_beat_t   i_ret;

  logic [`ICACHE_ADDR_W-1:0] pend_addr [$];  // accepted but not yet answered
  int                        pend_cyc [$];
  int                        pend_grants [$];
  int                        cyc;
  int                        grants;          // bus reads granted so far

  icache_top icache_top_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_addr    (i_addr),
    .o_addr_ok (o_addr_ok),
    .o_data_ok (o_data_ok),
    .o_rdata   (o_rdata),
    .o_rd      (o_rd),
    .i_rd_rdy  (i_rd_rdy),
    .i_ret     (i_ret)
  );

  always #10 i_clk = ~i_clk;

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------

  // memory contents as a hash of the word address
  function automatic word_t mem_word(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [31:0] w;
    w = {3'b000, addr[31:3]};
    return {(w * 32'h9e3779b1) ^ 32'hc2b2ae35, (~w) ^ (w << 7) ^ 32'h27d4eb2f};
  endfunction

  function automatic logic [`ICACHE_ADDR_W-1:0] make_addr(input int tag, input int index,
                                                         input int offset);
    return {tag[`ICACHE_TAG_W-1:0], index[`ICACHE_INDEX_W-1:0], offset[`ICACHE_OFFSET_W-1:0]};
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // called on a falling edge and returns on the falling edge after acceptance
  task automatic issue_read(input logic [`ICACHE_ADDR_W-1:0] addr, output int acc_cyc);
    i_valid = 1'b1;
    i_addr  = addr;
    #1;
    while (!o_addr_ok) begin  // hold the request
      @(negedge i_clk);
      #1;
    end
    acc_cyc = cyc;
    pend_addr.push_back(addr);
    pend_cyc.push_back(cyc);
    pend_grants.push_back(grants);
    @(negedge i_clk);
    i_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (pend_addr.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  task automatic read_expect(input logic [`ICACHE_ADDR_W-1:0] addr, input int exp_miss);
    int g0;
    int acc;
    g0 = grants;
    issue_read(addr, acc);
    wait_idle();
    check_value("bus requests", 64'(grants - g0), 64'(exp_miss));
  endtask

  // --------------------------------------------------
  // bus memory responder
  // --------------------------------------------------

  always begin : responder
    logic [`ICACHE_ADDR_W-1:0] line;
    @(negedge i_clk);
    if (!i_rst && o_rd.req) begin
      line = o_rd.addr;
      repeat ($urandom_range(0, 2)) @(negedge i_clk);  // random ready delay
      i_rd_rdy = 1'b1;
      @(negedge i_clk);
      i_rd_rdy = 1'b0;
      for (int b = 0; b < `ICACHE_BEATS; b++) begin
        repeat ($urandom_range(0, 1)) @(negedge i_clk);  // gap between beats
        i_ret.valid = 1'b1;
        i_ret.last  = (b == `ICACHE_BEATS - 1);
        i_ret.data  = mem_word(line + 32'(b * 8));
        @(negedge i_clk);
        i_ret.valid = 1'b0;
        i_ret.last  = 1'b0;
      end
      #1;
      check_value("o_addr_ok", 64'(o_addr_ok), 64'd1);  // idle right after the last beat
    end
  end

  // --------------------------------------------------
  // compare process and cycle limit
  // --------------------------------------------------

  always begin : monitor
    logic [`ICACHE_ADDR_W-1:0] head;
    @(negedge i_clk);
    #5;  // mid-cycle with inputs settled
    if (!i_rst) begin
      if (o_rd.req) begin
        if (pend_addr.size() == 0) begin
          $display("bus read request raised with no CPU read outstanding");
          abort_run();
        end else begin
          head = pend_addr[0];
          check_value("o_rd.addr", 64'(o_rd.addr), 64'({head[31:5], 5'b00000}));
          if (i_rd_rdy) begin
            grants++;
          end
        end
      end
      if (o_data_ok) begin
        if (pend_addr.size() == 0) begin
          $display("o_data_ok pulsed with no CPU read outstanding");
          abort_run();
        end else begin
          check_value("o_rdata", o_rdata, mem_word(pend_addr[0]));
          if (pend_grants[0] == grants) begin  // a hit answers in the next cycle
            check_value("o_data_ok latency", 64'(cyc - pend_cyc[0]), 64'd1);
          end
          void'(pend_addr.pop_front());
          void'(pend_cyc.pop_front());
          void'(pend_grants.pop_front());
        end
      end
    end
    cyc++;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin : main
    int                        acc;
    int                        prev;
    int                        g0;
    logic [`ICACHE_ADDR_W-1:0] a;
    logic [`ICACHE_ADDR_W-1:0] b;
    logic [`ICACHE_ADDR_W-1:0] c;
    void'($urandom(98122));
    i_clk    = 1'b0;
    i_rst    = 1'b1;
    i_valid  = 1'b0;
    i_addr   = '0;
    i_rd_rdy = 1'b0;
    i_ret    = '0;
    cyc      = 0;
    grants   = 0;
    prev     = 0;
    repeat (10) @(negedge i_clk);
    i_rst = 1'b0;
    #5;
    check_value("o_data_ok", 64'(o_data_ok), 64'd0);
    check_value("o_rd.req", 64'(o_rd.req), 64'd0);
    @(negedge i_clk);

    // cold misses with the critical word at each of the four offsets
    for (int w = 0; w < 4; w++) begin
      read_expect(make_addr(5, 8 + w, w * 8 + w), 1);
    end
    // same lines again on other words
    for (int w = 0; w < 4; w++) begin
      read_expect(make_addr(5, 8 + w, ((w + 2) % 4) * 8), 0);
    end

    // three lines on one set with round-robin starting at way 0
    a = make_addr(32'h100, 20, 0);
    b = make_addr(32'h101, 20, 8);
    c = make_addr(32'h102, 20, 24);
    read_expect(a, 1);
    read_expect(b, 1);
    read_expect(a, 0);
    read_expect(b, 0);
    read_expect(c, 1);   // evicts a
    read_expect(b, 0);
    read_expect(a, 1);

    // back-to-back hits
    g0 = grants;
    for (int w = 0; w < 4; w++) begin
      issue_read(make_addr(5, 8 + w, (3 - w) * 8), acc);
      if (w > 0) begin
        check_value("accept cycle step", 64'(acc - prev), 64'd1);
      end
      prev = acc;
    end
    wait_idle();
    check_value("bus requests", 64'(grants - g0), 64'd0);

    // random reads over 12 lines in 4 sets
    g0 = grants;
    for (int i = 0; i < RAND_READS; i++) begin
      issue_read(make_addr($urandom_range(64, 66), $urandom_range(32, 35),
                           $urandom_range(0, 31)), acc);
      if ($urandom_range(0, 3) == 0) begin
        @(negedge i_clk);
      end
    end
    wait_idle();
    $display("random reads done with %0d misses", grants - g0);
    while (!o_addr_ok) begin  // the last refill may still be running
      @(negedge i_clk);
    end
    @(negedge i_clk);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/icache_pkg.sv
design/icache_ctrl.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_miss_buffer.sv
design/icache_top.sv
dv/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/100ps \
  --top-module icache_tb \
  -f list.f \
  -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
